// ==== design/hdmi_pkg.sv ====
//====================
// Packet layouts put byte 0 and bit 0 in the LSBs, the order they go out on TMDS
// Parity sits above the payload in each coded word
//====================
`default_nettype none

package hdmi_pkg;

    // Packet header, hb0 is the packet type
    typedef struct packed {
        logic [7:0] hb2;
        logic [7:0] hb1;
        logic [7:0] hb0;
    } header_t;

    typedef struct packed {
        logic [7:0] sb6;
        logic [7:0] sb5;
        logic [7:0] sb4;
        logic [7:0] sb3;
        logic [7:0] sb2;
        logic [7:0] sb1;
        logic [7:0] sb0;
    } subpacket_t;

    typedef struct packed {
        subpacket_t [3:0] sub;  // Four subpackets, sub[0] in the LSBs
        header_t          hdr;
    } packet_t;

    typedef struct packed {
        logic [7:0] parity;     // Coded bits 31:24
        header_t    hdr;
    } coded_header_t;

    typedef struct packed {
        logic [7:0] parity;     // Coded bits 63:56
        subpacket_t sub;
    } coded_subpacket_t;

    // One pixel of island data
    typedef struct packed {
        logic       valid;
        logic       first;      // Beat 0 of a packet
        logic       hdr_bit;    // Channel 0 bit 2
        logic [3:0] ch1;        // Bit i from subpacket i
        logic [3:0] ch2;        // Bit i from subpacket i
    } island_beat_t;

    // x^8+x^7+x^6+1 for an LSB-first right-shifting remainder
    localparam logic [7:0] BCH_POLY = 8'h83;
    localparam int ECC_LATENCY = 1;  // Cycles from ECC input to coded output

    localparam logic [7:0] PKT_TYPE_NULL = 8'h00;
    localparam logic [7:0] PKT_TYPE_ACR  = 8'h01;

endpackage

`default_nettype wire

// ==== design/audio_clock_regeneration_packet.sv ====
//====================
// clk_audio must run for two edges before the audio side leaves reset
// CTS is measured over one wrap period, the counter allows 10% audio clock error
//====================
`timescale 1ns/1ps
`default_nettype none

module audio_clock_regeneration_packet
#(
    parameter int VIDEO_RATE = 25_200_000,
    parameter int AUDIO_RATE = 48_000
)
(
    input  logic              clk_pixel,
    input  logic              rst,
    input  logic              clk_audio,
    output logic              acr_event,
    output hdmi_pkg::packet_t acr_packet
);

    localparam int N_INT = (AUDIO_RATE % 125 == 0) ? 16 * AUDIO_RATE / 125 :
                           (AUDIO_RATE % 225 == 0) ? 196 * AUDIO_RATE / 225 :
                           16 * AUDIO_RATE / 125;
    localparam logic [19:0] N = 20'(N_INT);
    localparam int DIV_W = $clog2(N_INT / 128);
    localparam int DIV_END = N_INT / 128 - 1;
    localparam longint CTS_IDEAL = longint'(VIDEO_RATE) * N_INT / 128 / AUDIO_RATE;
    localparam int TS_W = $clog2(CTS_IDEAL * 11 / 10);

    // Audio domain
    logic [1:0]       audio_rst_sync = 2'b11;  // Starts in reset until clk_audio runs
    logic [DIV_W-1:0] div_count = '0;
    logic             wrap_toggle = 1'b0;

    // Pixel domain
    logic [1:0]       wrap_sync;
    logic             wrap_seen;
    logic             wrap_edge;
    logic [TS_W-1:0]  ts_count;
    logic [19:0]      cts;

    always_ff @(posedge clk_audio)
    begin
        audio_rst_sync <= {audio_rst_sync[0], rst};
    end

    always_ff @(posedge clk_audio)
    begin
        if (audio_rst_sync[1])
        begin
            div_count <= '0;
            wrap_toggle <= 1'b0;
        end
        else if (div_count == DIV_W'(DIV_END))
        begin
            div_count <= '0;
            wrap_toggle <= ~wrap_toggle;         // One flip per N/128 audio cycles
        end
        else
        begin
            div_count <= div_count + 1'b1;
        end
    end

    assign wrap_edge = wrap_sync[1] ^ wrap_seen;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            wrap_sync <= '0;
            wrap_seen <= 1'b0;
            acr_event <= 1'b0;
            ts_count <= '0;
        end
        else
        begin
            wrap_sync <= {wrap_sync[0], wrap_toggle};
            wrap_seen <= wrap_sync[1];
            acr_event <= wrap_edge;              // Third pixel edge after the flip
            ts_count <= wrap_edge ? '0 : ts_count + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (wrap_edge)
            cts <= 20'(ts_count) + 20'd1;        // Cycles since the previous wrap
    end

    // All four subpackets carry the same CTS and N
    always_comb
    begin
        acr_packet.hdr.hb0 = hdmi_pkg::PKT_TYPE_ACR;
        acr_packet.hdr.hb1 = 8'd0;
        acr_packet.hdr.hb2 = 8'd0;
        for (int i = 0; i < 4; i++)
        begin
            acr_packet.sub[i].sb0 = 8'd0;
            acr_packet.sub[i].sb1 = {4'd0, cts[19:16]};
            acr_packet.sub[i].sb2 = cts[15:8];
            acr_packet.sub[i].sb3 = cts[7:0];
            acr_packet.sub[i].sb4 = {4'd0, N[19:16]};
            acr_packet.sub[i].sb5 = N[15:8];
            acr_packet.sub[i].sb6 = N[7:0];
        end
    end

    // A wrap crosses as a single pulse
    acr_event_single: assert property (@(posedge clk_pixel) disable iff (rst)
        acr_event |=> !acr_event);

endmodule

`default_nettype wire

// ==== design/packet_picker.sv ====
//====================
// Sends ACR when a wrap is pending, null packets otherwise
// Wraps that arrive while one is pending are merged
//====================
`timescale 1ns/1ps
`default_nettype none

module packet_picker
(
    input  logic              clk_pixel,
    input  logic              rst,
    input  logic              acr_event,
    input  hdmi_pkg::packet_t acr_packet,
    input  logic              ack,
    output logic              req,
    output hdmi_pkg::packet_t packet
);

    localparam int WAIT_W = (hdmi_pkg::ECC_LATENCY > 1) ? $clog2(hdmi_pkg::ECC_LATENCY) : 1;

    typedef enum logic [1:0] {
        S_LOAD,
        S_WAIT,
        S_REQ,
        S_RELEASE
    } state_t;

    state_t            state;
    logic [WAIT_W-1:0] wait_count;
    logic              pending;
    hdmi_pkg::packet_t null_packet;

    always_comb
    begin
        null_packet = '0;
        null_packet.hdr.hb0 = hdmi_pkg::PKT_TYPE_NULL;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            pending <= 1'b0;
        else if (state == S_LOAD && pending)
            pending <= 1'b0;                     // A wrap in this cycle merges into the load
        else if (acr_event)
            pending <= 1'b1;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            state <= S_LOAD;
            req <= 1'b0;
            wait_count <= '0;
        end
        else
        begin
            case (state)
                S_LOAD:
                begin
                    wait_count <= '0;
                    state <= S_WAIT;
                end
                S_WAIT:
                begin
                    if (wait_count == WAIT_W'(hdmi_pkg::ECC_LATENCY - 1))
                    begin
                        req <= 1'b1;             // Coded words valid from here
                        state <= S_REQ;
                    end
                    else
                    begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                S_REQ:
                begin
                    if (ack)
                    begin
                        req <= 1'b0;
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE:
                begin
                    if (!ack)
                        state <= S_LOAD;
                end
                default: state <= S_LOAD;
            endcase
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (state == S_LOAD)
            packet <= pending ? acr_packet : null_packet;
    end

    packet_held: assert property (@(posedge clk_pixel) disable iff (rst)
        req |=> (!req || $stable(packet)));

endmodule

`default_nettype wire

// ==== design/packet_ecc.sv ====
//====================
// coded_t must be payload_t with an 8-bit parity on top
//====================
`timescale 1ns/1ps
`default_nettype none

module packet_ecc
#(
    parameter type payload_t = hdmi_pkg::header_t,
    parameter type coded_t   = hdmi_pkg::coded_header_t
)
(
    input  logic     clk_pixel,
    input  logic     rst,
    input  payload_t payload,
    output coded_t   coded
);

    localparam int PAYLOAD_W = $bits(payload_t);

    logic [PAYLOAD_W-1:0] payload_bits;
    logic [7:0]           parity;

    assign payload_bits = payload;

    // Remainder register, payload bit 0 shifted in first
    always_comb
    begin
        parity = 8'd0;
        for (int i = 0; i < PAYLOAD_W; i++)
        begin
            if (parity[0] ^ payload_bits[i])
                parity = (parity >> 1) ^ hdmi_pkg::BCH_POLY;
            else
                parity = parity >> 1;
        end
    end

    // Single register stage, matches ECC_LATENCY
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            coded <= '0;
        else
            coded <= coded_t'({parity, payload_bits});
    end

endmodule

`default_nettype wire

// ==== design/packet_assembler.sv ====
//====================
// Beats are combinational and only valid while island_window is high
// The next packet is latched only after beat 31 and a fresh req
//====================
`timescale 1ns/1ps
`default_nettype none

module packet_assembler
(
    input  logic                                clk_pixel,
    input  logic                                rst,
    input  logic                                req,
    input  hdmi_pkg::coded_header_t             coded_header,
    input  hdmi_pkg::coded_subpacket_t [3:0]    coded_sub,
    input  logic                                island_window,
    output logic                                ack,
    output hdmi_pkg::island_beat_t              beat
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_LATCHED,
        HS_ACK
    } hs_state_t;

    hs_state_t        hs_state;
    logic             latch;
    logic             busy;
    logic [4:0]       beat_idx;
    logic [5:0]       bit_even;
    logic [5:0]       bit_odd;
    logic [31:0]      hdr_bits;
    logic [3:0][63:0] sub_bits;

    assign latch = (hs_state == HS_IDLE) && !busy && req;
    assign bit_even = {beat_idx, 1'b0};
    assign bit_odd = {beat_idx, 1'b1};

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            hs_state <= HS_IDLE;
            ack <= 1'b0;
        end
        else
        begin
            case (hs_state)
                HS_IDLE:
                begin
                    if (latch)
                        hs_state <= HS_LATCHED;
                end
                HS_LATCHED:
                begin
                    ack <= 1'b1;                 // Cycle after the latch
                    hs_state <= HS_ACK;
                end
                HS_ACK:
                begin
                    if (!req)
                    begin
                        ack <= 1'b0;
                        hs_state <= HS_IDLE;
                    end
                end
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (latch)
        begin
            hdr_bits <= coded_header;
            sub_bits <= coded_sub;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            beat_idx <= '0;
        end
        else if (latch)
        begin
            busy <= 1'b1;
            beat_idx <= '0;
        end
        else if (busy && island_window)
        begin
            beat_idx <= beat_idx + 1'b1;         // Holds while the window is closed
            if (beat_idx == 5'd31)
                busy <= 1'b0;
        end
    end

    always_comb
    begin
        beat.valid = busy && island_window;
        beat.first = busy && island_window && (beat_idx == 5'd0);
        beat.hdr_bit = hdr_bits[beat_idx];
        for (int i = 0; i < 4; i++)
        begin
            beat.ch1[i] = sub_bits[i][bit_even];
            beat.ch2[i] = sub_bits[i][bit_odd];
        end
    end

    ack_needs_req: assert property (@(posedge clk_pixel) disable iff (rst)
        $rose(ack) |-> req);

    // Valid beats carry coded words that had settled when latched
    beat_known: assert property (@(posedge clk_pixel) disable iff (rst)
        beat.valid |-> !$isunknown(beat));

endmodule

`default_nettype wire

// ==== design/hdmi_packet_top.sv ====
//====================
// island_window stands in for video timing, no TMDS or TERC4 coding here
//====================
`timescale 1ns/1ps
`default_nettype none

module hdmi_packet_top
#(
    parameter int VIDEO_RATE = 25_200_000,
    parameter int AUDIO_RATE = 48_000
)
(
    input  logic                   clk_pixel,
    input  logic                   rst,
    input  logic                   clk_audio,
    input  logic                   island_window,
    output hdmi_pkg::island_beat_t beat
);

    logic                             acr_event;
    hdmi_pkg::packet_t                acr_packet;
    hdmi_pkg::packet_t                packet;
    logic                             req;
    logic                             ack;
    hdmi_pkg::coded_header_t          coded_header;
    hdmi_pkg::coded_subpacket_t [3:0] coded_sub;

    audio_clock_regeneration_packet #(
        .VIDEO_RATE (VIDEO_RATE),
        .AUDIO_RATE (AUDIO_RATE)
    ) u_acr (
        .clk_pixel  (clk_pixel),
        .rst        (rst),
        .clk_audio  (clk_audio),
        .acr_event  (acr_event),
        .acr_packet (acr_packet)
    );

    packet_picker u_picker (
        .clk_pixel  (clk_pixel),
        .rst        (rst),
        .acr_event  (acr_event),
        .acr_packet (acr_packet),
        .ack        (ack),
        .req        (req),
        .packet     (packet)
    );

    packet_ecc #(
        .payload_t (hdmi_pkg::header_t),
        .coded_t   (hdmi_pkg::coded_header_t)
    ) u_hdr_ecc (
        .clk_pixel (clk_pixel),
        .rst       (rst),
        .payload   (packet.hdr),
        .coded     (coded_header)
    );

    for (genvar i = 0; i < 4; i++)
    begin : g_sub_ecc
        packet_ecc #(
            .payload_t (hdmi_pkg::subpacket_t),
            .coded_t   (hdmi_pkg::coded_subpacket_t)
        ) u_sub_ecc (
            .clk_pixel (clk_pixel),
            .rst       (rst),
            .payload   (packet.sub[i]),
            .coded     (coded_sub[i])
        );
    end

    packet_assembler u_assembler (
        .clk_pixel     (clk_pixel),
        .rst           (rst),
        .req           (req),
        .coded_header  (coded_header),
        .coded_sub     (coded_sub),
        .island_window (island_window),
        .ack           (ack),
        .beat          (beat)
    );

endmodule

`default_nettype wire

// ==== bench/tb_tasks.svh ====
//====================
// Included inside tb_hdmi_packet, uses its signals and packet queue
// Tests run in order since they follow the audio wraps as they happen
//====================
`default_nettype none

    // x^7, x^6 and x^0 terms of x^8+x^7+x^6+1
    localparam logic [7:0] GEN_TAPS = 8'b1100_0001;

    rx_packet_t first_acr;
    rx_packet_t second_acr;
    bit         have_first;
    bit         have_second;

    // Remainder after shifting in bit 0 first, from all zeros
    function automatic logic [7:0] bch_parity(input logic [63:0] bits, input int width);
        logic [7:0] mask;
        logic [7:0] rem;
        logic       fb;
        for (int j = 0; j < 8; j++)
            mask[j] = GEN_TAPS[7 - j];                 // Reflected for right shifting
        rem = 8'h00;
        for (int i = 0; i < width; i++)
        begin
            fb = rem[0] ^ bits[i];
            rem = rem >> 1;
            if (fb)
                rem = rem ^ mask;
        end
        return rem;
    endfunction

    function automatic int expected_n(input int rate);
        if (rate % 125 == 0)
            return 16 * rate / 125;
        else if (rate % 225 == 0)
            return 196 * rate / 225;
        else
            return 16 * rate / 125;
    endfunction

    // Ideal pixel cycles between two wraps, also the ideal CTS
    function automatic int wrap_cycles();
        return int'(longint'(VIDEO_RATE) * expected_n(AUDIO_RATE) / (128 * longint'(AUDIO_RATE)));
    endfunction

    function automatic logic [19:0] cts_of(input logic [63:0] sub);
        return {sub[11:8], sub[23:16], sub[31:24]};    // sb1 low nibble, sb2, sb3
    endfunction

    function automatic logic [19:0] n_of(input logic [63:0] sub);
        return {sub[35:32], sub[47:40], sub[55:48]};   // sb4 low nibble, sb5, sb6
    endfunction

    task automatic log_mismatch(input string test, input string field,
                                input logic [63:0] expected, input logic [63:0] actual);
        $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test, field, expected, actual);
        error_count++;
    endtask

    task automatic finish_test(input string test, input int errs0);
        $display("%-12s done, %0d errors", test, error_count - errs0);
        tests_run++;
    endtask

    // Pops the next decoded packet, ok is low if none came in time
    task automatic next_packet(output rx_packet_t pkt, output bit ok);
        int waited;
        waited = 0;
        while (rx_queue.size() == 0 && waited < PACKET_WAIT)
        begin
            @(negedge clk_pixel);
            waited++;
        end
        ok = (rx_queue.size() != 0);
        if (ok)
            pkt = rx_queue.pop_front();
    endtask

    task automatic check_null(input string test, input rx_packet_t pkt);
        if (pkt.hdr !== 32'h0)
            log_mismatch(test, "null header", 64'h0, 64'(pkt.hdr));
        for (int i = 0; i < 4; i++)
        begin
            if (pkt.sub[i] !== 64'h0)
                log_mismatch(test, $sformatf("null sub%0d", i), 64'h0, pkt.sub[i]);
        end
    endtask

    task automatic check_parity(input string test, input rx_packet_t pkt);
        logic [7:0] expected;
        expected = bch_parity(64'(pkt.hdr[23:0]), 24);
        if (pkt.hdr[31:24] !== expected)
            log_mismatch(test, "header parity", 64'(expected), 64'(pkt.hdr[31:24]));
        for (int i = 0; i < 4; i++)
        begin
            expected = bch_parity(64'(pkt.sub[i][55:0]), 56);
            if (pkt.sub[i][63:56] !== expected)
                log_mismatch(test, $sformatf("sub%0d parity", i), 64'(expected),
                             64'(pkt.sub[i][63:56]));
        end
    endtask

    task automatic check_acr(input string test, input rx_packet_t pkt, input bit check_cts);
        logic [19:0] cts;
        cts = cts_of(pkt.sub[0]);
        if (pkt.hdr[7:0] !== 8'h01)
            log_mismatch(test, "hb0", 64'h01, 64'(pkt.hdr[7:0]));
        if (pkt.hdr[15:8] !== 8'h00)
            log_mismatch(test, "hb1", 64'h00, 64'(pkt.hdr[15:8]));
        if (pkt.hdr[23:16] !== 8'h00)
            log_mismatch(test, "hb2", 64'h00, 64'(pkt.hdr[23:16]));
        for (int i = 1; i < 4; i++)
        begin
            if (pkt.sub[i] !== pkt.sub[0])
                log_mismatch(test, $sformatf("sub%0d", i), pkt.sub[0], pkt.sub[i]);
        end
        if (pkt.sub[0][7:0] !== 8'h00)
            log_mismatch(test, "sb0", 64'h0, 64'(pkt.sub[0][7:0]));
        if ({pkt.sub[0][15:12], pkt.sub[0][39:36]} !== 8'h00)
            log_mismatch(test, "sb1 and sb4 upper nibbles", 64'h0,
                         64'({pkt.sub[0][15:12], pkt.sub[0][39:36]}));
        if (n_of(pkt.sub[0]) !== 20'(expected_n(AUDIO_RATE)))
            log_mismatch(test, "N", 64'(expected_n(AUDIO_RATE)), 64'(n_of(pkt.sub[0])));
        if (check_cts && (cts < wrap_cycles() - 1 || cts > wrap_cycles() + 1))
            log_mismatch(test, "CTS", 64'(wrap_cycles()), 64'(cts));
    endtask

    // Skips null packets, checking each, until an ACR packet shows up
    task automatic wait_acr(input string test, output rx_packet_t pkt, output bit ok);
        int unsigned start;
        bit          got;
        start = cycle_count;
        ok = 1'b0;
        while (!ok && (cycle_count - start) < wrap_cycles() + 2000)
        begin
            next_packet(pkt, got);
            if (got && pkt.hdr[7:0] === 8'h01)
                ok = 1'b1;
            else if (got)
                check_null(test, pkt);
        end
        if (!ok)
        begin
            $display("%s: no ACR packet arrived within %0d cycles", test, wrap_cycles() + 2000);
            error_count++;
        end
    endtask

    task automatic test_reset_null();
        rx_packet_t pkt;
        bit         ok;
        int         errs0;
        errs0 = error_count;
        rst = 1'b1;
        repeat (RESET_CYCLES)
        begin
            @(posedge clk_pixel);
            #(SAMPLE_NS);
            if (beat.valid !== 1'b0)
                log_mismatch("reset_null", "beat.valid in reset", 64'h0, 64'(beat.valid));
        end
        @(negedge clk_pixel);
        rst = 1'b0;
        next_packet(pkt, ok);
        if (!ok)
        begin
            $display("reset_null: no packet came out after reset");
            error_count++;
        end
        else
            check_null("reset_null", pkt);
        finish_test("reset_null", errs0);
    endtask

    task automatic test_first_acr();
        rx_packet_t pkt;
        int         errs0;
        errs0 = error_count;
        wait_acr("first_acr", pkt, have_first);
        if (have_first)
        begin
            check_acr("first_acr", pkt, 1'b0);     // First CTS spans reset to wrap
            first_acr = pkt;
        end
        finish_test("first_acr", errs0);
    endtask

    task automatic test_cts();
        rx_packet_t pkt;
        int         errs0;
        errs0 = error_count;
        wait_acr("cts", pkt, have_second);
        if (have_second)
        begin
            check_acr("cts", pkt, 1'b1);
            second_acr = pkt;
        end
        finish_test("cts", errs0);
    endtask

    task automatic test_parity();
        rx_packet_t pkt;
        bit         ok;
        int         errs0;
        errs0 = error_count;
        if (have_first)
            check_parity("parity", first_acr);
        if (have_second)
            check_parity("parity", second_acr);
        repeat (16)
        begin
            next_packet(pkt, ok);
            if (!ok)
            begin
                $display("parity: packet stream stopped");
                error_count++;
                break;
            end
            check_parity("parity", pkt);
        end
        finish_test("parity", errs0);
    endtask

    task automatic test_window_gaps();
        rx_packet_t pkt;
        bit         ok;
        int         errs0;
        errs0 = error_count;
        rx_queue.delete();
        gaps_on = 1'b1;
        wait_acr("window_gaps", pkt, ok);
        if (ok)
        begin
            check_acr("window_gaps", pkt, 1'b1);
            check_parity("window_gaps", pkt);
        end
        repeat (4)
        begin
            next_packet(pkt, ok);
            if (!ok)
            begin
                $display("window_gaps: packet stream stopped under window gaps");
                error_count++;
                break;
            end
            check_null("window_gaps", pkt);
        end
        gaps_on = 1'b0;
        if (gaps_started == 0)
        begin
            $display("window_gaps: island_window never dropped");
            error_count++;
        end
        finish_test("window_gaps", errs0);
    endtask

`default_nettype wire

// ==== bench/tb_hdmi_packet.sv ====
//====================
// Runs about 3.2 ms of simulated time, the ACR tests wait for real audio wraps
// Beats are sampled in the middle of the low phase of clk_pixel
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_packet;

    localparam int  VIDEO_RATE = 10_000_000;
    localparam int  AUDIO_RATE = 48_000;
    localparam int  RESET_CYCLES = 4;
    localparam int  PACKET_WAIT = 200;                 // Cycles allowed between two packets
    localparam real PIXEL_HALF_NS = 1.0e9 / (2.0 * VIDEO_RATE);
    localparam real AUDIO_HALF_NS = 1.0e9 / (2.0 * AUDIO_RATE);
    localparam real SAMPLE_NS = PIXEL_HALF_NS / 2.0;

    // One packet as rebuilt from the beats
    typedef struct packed {
        logic [3:0][63:0] sub;                         // Parity in bits 63:56
        logic [31:0]      hdr;                         // Parity in bits 31:24
    } rx_packet_t;

    logic                   clk_pixel = 1'b0;
    logic                   clk_audio = 1'b0;
    logic                   rst;
    logic                   island_window;
    hdmi_pkg::island_beat_t beat;

    rx_packet_t       rx_queue[$];
    logic [31:0]      rx_hdr;
    logic [3:0][63:0] rx_sub;
    int               rx_beats;
    bit               collecting;
    int               packets_decoded;

    int          seed = 32'h627be7fc;
    logic [31:0] rnd;
    bit          gaps_on;
    int          gap_left;
    int          gaps_started;

    int          error_count;
    int          tests_run;
    int unsigned cycle_count = 0;

    always #(PIXEL_HALF_NS) clk_pixel = ~clk_pixel;
    always #(AUDIO_HALF_NS) clk_audio = ~clk_audio;

    always @(posedge clk_pixel)
        cycle_count <= cycle_count + 1;

    hdmi_packet_top #(
        .VIDEO_RATE (VIDEO_RATE),
        .AUDIO_RATE (AUDIO_RATE)
    ) UUT (
        .clk_pixel     (clk_pixel),
        .rst           (rst),
        .clk_audio     (clk_audio),
        .island_window (island_window),
        .beat          (beat)
    );

    // Island window, held high unless random gaps are on
    always @(negedge clk_pixel)
    begin
        if (!gaps_on)
            island_window = 1'b1;
        else if (gap_left > 0)
        begin
            island_window = 1'b0;
            gap_left = gap_left - 1;
        end
        else
        begin
            rnd = $random(seed);
            if (rnd[2:0] == 3'd0)                      // About one cycle in eight opens a gap
            begin
                island_window = 1'b0;
                gap_left = int'(rnd[15:8]) % 5;        // 1 to 5 low cycles in total
                gaps_started++;
            end
            else
                island_window = 1'b1;
        end
    end

    // Beat collector, rebuilds coded words from 32 valid beats
    always
    begin
        @(negedge clk_pixel);
        #(SAMPLE_NS);
        if (rst)
        begin
            collecting = 1'b0;
            rx_beats = 0;
        end
        else if (beat.valid)
        begin
            if (beat.first && collecting)
            begin
                $display("Packet cut short, beat.first came after %0d beats", rx_beats);
                error_count++;
            end
            if (beat.first)
            begin
                collecting = 1'b1;
                rx_beats = 0;
            end
            if (!collecting)
            begin
                $display("Valid beat outside any packet at cycle %0d", cycle_count);
                error_count++;
            end
            else
            begin
                rx_hdr[rx_beats] = beat.hdr_bit;
                for (int i = 0; i < 4; i++)
                begin
                    rx_sub[i][2 * rx_beats] = beat.ch1[i];
                    rx_sub[i][2 * rx_beats + 1] = beat.ch2[i];
                end
                rx_beats++;
                if (rx_beats == 32)
                begin
                    rx_queue.push_back({rx_sub, rx_hdr});
                    packets_decoded++;
                    collecting = 1'b0;
                end
            end
        end
    end

    // Four wrap periods plus half a period of margin
    initial
    begin : watchdog
        int limit;
        limit = 4 * wrap_cycles() + wrap_cycles() / 2;
        repeat (limit) @(posedge clk_pixel);
        $display("Watchdog expired after %0d cycles, the tests did not finish", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        island_window = 1'b1;
        gaps_on = 1'b0;
        gap_left = 0;
        gaps_started = 0;
        collecting = 1'b0;
        rx_beats = 0;
        packets_decoded = 0;
        error_count = 0;
        tests_run = 0;
        test_reset_null();
        test_first_acr();
        test_cts();
        test_parity();
        test_window_gaps();
        $display("Tests run %0d, packets decoded %0d, window gaps %0d, errors %0d",
                 tests_run, packets_decoded, gaps_started, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

`include "tb_tasks.svh"

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+bench
design/hdmi_pkg.sv
design/audio_clock_regeneration_packet.sv
design/packet_picker.sv
design/packet_ecc.sv
design/packet_assembler.sv
design/hdmi_packet_top.sv
bench/tb_hdmi_packet.sv

// ==== Makefile ====
# Verilator build and run for the HDMI data-island packet path
# Override any variable on the command line, e.g. make LOG=run2.log

VERILATOR  ?= verilator
TOP        ?= tb_hdmi_packet
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
